//--- files.f
design/dec_ib_pkg.sv
design/ib_ctl.sv
design/ib_slots.sv
design/dbg_inst_gen.sv
design/dec_ib.sv
test/dec_ib_asserts.sv
test/tb_dec_ib.sv

//--- Makefile
# Verilator build and run of the dec_ib testbench
# override on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_dec_ib
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= TESTBENCH FAILED

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_dec_ib.sv
// a queue model of the buffer contents is checked against dec_ib every cycle
// inputs change on the falling edge and the model checks and advances on the rising edge
// decode only on valid slots and debug commands only on an empty buffer
// random stimulus from $urandom with a fixed seed

`timescale 1ns/1ps
`default_nettype none

module tb_dec_ib;
   import dec_ib_pkg::*;

   localparam int ib_depth   = 4;
   localparam int max_cycles = 4000;    // about twice the stimulus length

   // risc-v fields of the expected debug instructions
   localparam logic [6:0]  op_reg    = 7'b0110011;
   localparam logic [6:0]  op_system = 7'b1110011;
   localparam logic [2:0]  f3_or     = 3'b110;
   localparam logic [2:0]  f3_csrrw  = 3'b001;
   localparam logic [2:0]  f3_csrrs  = 3'b010;
   localparam logic [11:0] fence_csr = 12'h7c4;

   logic                clk = 1'b0;
   logic                rst_n;
   logic                flush;
   ib_fetch_t           fetch0;
   ib_fetch_t           fetch1;
   dbg_cmd_t            dbg_cmd;
   logic                decode0;
   logic                decode1;
   logic [ib_depth-1:0] ib_valid;
   ib_entry_t           dec0;
   ib_entry_t           dec1;
   logic                debug_wdata_rs1;
   logic                debug_fence;

   ib_entry_t exp_q[$];        // model of the buffer with the head at index 0
   logic      exp_flush_q;
   logic      exp_rs1;
   logic      exp_fence;

   int cycle_count = 0;
   int n_refused   = 0;
   int n_flush     = 0;
   int n_debug     = 0;
   int n_fence     = 0;

   dec_ib #(
      .ib_depth(ib_depth)
   ) DUT (
      .clk             (clk),
      .rst_n           (rst_n),
      .flush           (flush),
      .fetch0          (fetch0),
      .fetch1          (fetch1),
      .dbg_cmd         (dbg_cmd),
      .decode0         (decode0),
      .decode1         (decode1),
      .ib_valid        (ib_valid),
      .dec0            (dec0),
      .dec1            (dec1),
      .debug_wdata_rs1 (debug_wdata_rs1),
      .debug_fence     (debug_fence)
   );

   always #4 clk = ~clk;

   task automatic stop_with_failure();
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_mismatch(input string what);
      $display("[FAIL] %0t ns: %s", $time, what);
      stop_with_failure();
   endtask

   function automatic logic debug_taken(input dbg_cmd_t c);
      return c.valid && (c.cmd_type == dbg_gpr || c.cmd_type == dbg_csr);
   endfunction

   // encoding built field by field from the instruction set
   function automatic logic [31:0] expected_debug_instr(input dbg_cmd_t c);
      logic [4:0]  regno;
      logic [11:0] csr;
      logic [31:0] instr;
      regno = c.addr.word[4:0];
      csr   = c.addr.word[11:0];
      instr = '0;
      if (c.valid && c.cmd_type == dbg_gpr) begin
         if (c.write) instr = {7'b0, 5'd0, 5'd0, f3_or, regno, op_reg};   // or reg, x0, x0
         else instr = {7'b0, 5'd0, regno, f3_or, 5'd0, op_reg};          // or x0, reg, x0
      end else if (c.valid && c.cmd_type == dbg_csr) begin
         if (c.write) instr = {csr, 5'd0, f3_csrrw, 5'd0, op_system};
         else instr = {csr, 5'd0, f3_csrrs, 5'd0, op_system};
      end
      return instr;
   endfunction

   function automatic ib_entry_t debug_entry(input dbg_cmd_t c);
      ib_entry_t e;
      e       = '0;                 // no pc and no faults
      e.instr = expected_debug_instr(c);
      e.pc4   = 1'b1;
      return e;
   endfunction

   function automatic ib_entry_t random_entry();
      ib_entry_t e;
      e.instr = $urandom();
      e.pc    = 31'($urandom());
      {e.pc4, e.icaf, e.icaf_second, e.perr, e.sbecc, e.dbecc} = 6'($urandom());
      return e;
   endfunction

   function automatic dbg_cmd_t make_command(input logic write, input dbg_type_e t,
                                             input logic [31:0] word);
      dbg_cmd_t c;
      c.valid     = 1'b1;
      c.write     = write;
      c.cmd_type  = t;
      c.addr.word = word;
      return c;
   endfunction

   function automatic dbg_cmd_t random_command();
      dbg_cmd_t    c;
      int unsigned kind;
      kind = $urandom_range(9, 0);
      c    = make_command(1'($urandom()), dbg_gpr, $urandom());
      if (kind == 0) begin
         c.cmd_type = dbg_mem;
      end else if (kind == 1) begin
         c.cmd_type = dbg_reserved;
      end else if (kind >= 6) begin
         c.cmd_type = dbg_csr;
         if ($urandom_range(2, 0) == 0) c.addr.csr.addr = fence_csr;
      end
      return c;
   endfunction

   task automatic check_outputs();
      logic [ib_depth-1:0] exp_valid;
      int                  n;
      n = exp_q.size();
      for (int i = 0; i < ib_depth; i++) exp_valid[i] = (i < n);
      assert (ib_valid == exp_valid) else
         report_mismatch($sformatf("ib_valid %b, expected %b", ib_valid, exp_valid));
      if (n > 0) begin
         assert (dec0 == exp_q[0]) else
            report_mismatch($sformatf("dec0 %h, expected %h", dec0, exp_q[0]));
      end
      if (n > 1) begin
         assert (dec1 == exp_q[1]) else
            report_mismatch($sformatf("dec1 %h, expected %h", dec1, exp_q[1]));
      end
      assert (debug_wdata_rs1 == exp_rs1) else
         report_mismatch($sformatf("debug_wdata_rs1 %b, expected %b", debug_wdata_rs1, exp_rs1));
      assert (debug_fence == exp_fence) else
         report_mismatch($sformatf("debug_fence %b, expected %b", debug_fence, exp_fence));
   endtask

   // one clock edge of the buffer with the inputs held since the falling edge
   task automatic advance_model();
      logic take0;
      logic take1;
      logic dbg;
      take0 = fetch0.valid && !ib_valid[ib_depth-1] && !exp_flush_q;   // room rule
      take1 = fetch1.valid && !ib_valid[ib_depth-2] && !exp_flush_q;
      dbg   = debug_taken(dbg_cmd);
      if (fetch0.valid && !take0 && !exp_flush_q) n_refused++;
      if (exp_flush_q) begin
         exp_q.delete();
      end else begin
         if (decode0) void'(exp_q.pop_front());
         if (decode1) void'(exp_q.pop_front());
         if (dbg) exp_q.push_back(debug_entry(dbg_cmd));
         if (take0) exp_q.push_back(fetch0.entry);
         if (take1) exp_q.push_back(fetch1.entry);
      end
      exp_flush_q = flush;
      exp_rs1     = dbg && dbg_cmd.write;
      exp_fence   = dbg && dbg_cmd.write && dbg_cmd.cmd_type == dbg_csr &&
                    dbg_cmd.addr.word[11:0] == fence_csr;
      if (flush) n_flush++;
      if (dbg) n_debug++;
      if (exp_fence) n_fence++;
   endtask

   always @(posedge clk) begin
      if (!rst_n) begin
         exp_q.delete();
         exp_flush_q = 1'b0;
         exp_rs1     = 1'b0;
         exp_fence   = 1'b0;
      end else begin
         check_outputs();
         advance_model();
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= max_cycles) begin
         $display("timeout: the run did not end within %0d cycles", max_cycles);
         stop_with_failure();
      end
   end

   task automatic set_idle();
      flush   = 1'b0;
      fetch0  = '0;
      fetch1  = '0;
      dbg_cmd = '0;
      decode0 = 1'b0;
      decode1 = 1'b0;
   endtask

   task automatic run_mixed(input int cycles, input logic use_decode, input logic use_flush);
      repeat (cycles) begin
         @(negedge clk);
         set_idle();
         fetch0.valid = ($urandom_range(3, 0) != 0);
         fetch0.entry = random_entry();
         fetch1.valid = fetch0.valid && ($urandom_range(1, 0) == 1);   // lane 1 only with lane 0
         fetch1.entry = random_entry();
         if (use_decode) begin
            decode0 = ib_valid[0] && ($urandom_range(2, 0) != 0);
            decode1 = decode0 && ib_valid[1] && ($urandom_range(1, 0) == 1);
         end
         if (use_flush) flush = ($urandom_range(7, 0) == 0);
      end
   endtask

   // decode with fetch off until the buffer is empty
   task automatic drain_buffer();
      @(negedge clk);
      set_idle();
      while (ib_valid != '0) begin
         decode0 = 1'b1;
         decode1 = ib_valid[1];
         @(negedge clk);
         set_idle();
      end
   endtask

   task automatic issue_command(input dbg_cmd_t c);
      @(negedge clk);
      set_idle();
      dbg_cmd = c;
      drain_buffer();      // entry and pulses are checked in the cycle that follows
   endtask

   initial begin
      rst_n = 1'b0;
      set_idle();
      void'($urandom(93));
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      run_mixed(800, 1'b1, 1'b0);          // order
      repeat (25) begin                     // room with decode held off
         run_mixed(6, 1'b0, 1'b0);
         drain_buffer();
      end
      run_mixed(600, 1'b1, 1'b1);          // flush
      drain_buffer();
      repeat (150) issue_command(random_command());

      issue_command(make_command(1'b1, dbg_csr, 32'h0000_07c4));
      issue_command(make_command(1'b1, dbg_csr, 32'h0000_07c5));
      issue_command(make_command(1'b0, dbg_csr, 32'h0000_07c4));
      issue_command(make_command(1'b1, dbg_mem, 32'h0000_07c4));
      issue_command(make_command(1'b1, dbg_reserved, 32'h0000_001f));
      issue_command(make_command(1'b1, dbg_gpr, 32'h0000_001f));
      repeat (3) @(negedge clk);

      $display("cycles %0d, refused offers %0d, flushes %0d, debug takes %0d, fences %0d",
               cycle_count, n_refused, n_flush, n_debug, n_fence);
      if (n_refused > 0 && n_flush > 0 && n_debug > 0 && n_fence > 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         $display("the stimulus missed a refused offer, a flush, a debug take or a fence");
         stop_with_failure();
      end
   end

endmodule

`default_nettype wire

//--- test/dec_ib_asserts.sv
// concurrent checks bound into every dec_ib instance
// sized by the ib_depth of the bound instance, needs ib_depth of 2 or more

`timescale 1ns/1ps
`default_nettype none

module dec_ib_asserts #(
   parameter int ib_depth = 4
) (
   input logic                clk,
   input logic                rst_n,
   input logic                flush,
   input logic [ib_depth-1:0] ib_valid,
   input logic                debug_wdata_rs1,
   input logic                debug_fence
);

   // no slot valid above an empty one
   valid_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
      ((ib_valid >> 1) & ~ib_valid) == '0)
      else $error("valid bits not contiguous from slot 0: %b", ib_valid);

   // flush is registered, valid bits clear at the edge after that
   flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
      $past(flush, 2) |-> (ib_valid == '0))
      else $error("valid bits still set two cycles after a flush: %b", ib_valid);

   // a fence only comes from a csr write
   fence_with_write: assert property (@(posedge clk) disable iff (!rst_n)
      debug_fence |-> debug_wdata_rs1)
      else $error("debug_fence pulsed without debug_wdata_rs1");

endmodule

bind dec_ib dec_ib_asserts #(
   .ib_depth(ib_depth)
) u_asserts (
   .clk             (clk),
   .rst_n           (rst_n),
   .flush           (flush),
   .ib_valid        (ib_valid),
   .debug_wdata_rs1 (debug_wdata_rs1),
   .debug_fence     (debug_fence)
);

`default_nettype wire

//--- design/dec_ib.sv
// dual-issue instruction buffer between fetch and decode, ib_depth entries
// fetch offers are levels, an offer refused by the room rule is lost
// decode1 is legal only with decode0 and ib_valid[1]
// debug commands only while halted: buffer empty and fetch0 not valid
// ib_depth from 2 to ib_max_depth

`timescale 1ns/1ps
`default_nettype none

module dec_ib #(
   parameter int ib_depth = 4
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  flush,            // execute and taken-branch flush
   input  dec_ib_pkg::ib_fetch_t fetch0,
   input  dec_ib_pkg::ib_fetch_t fetch1,           // only with fetch0
   input  dec_ib_pkg::dbg_cmd_t  dbg_cmd,
   input  logic                  decode0,
   input  logic                  decode1,
   output logic [ib_depth-1:0]   ib_valid,
   output dec_ib_pkg::ib_entry_t dec0,
   output dec_ib_pkg::ib_entry_t dec1,
   output logic                  debug_wdata_rs1,
   output logic                  debug_fence
);
   import dec_ib_pkg::*;

   ib_sel_t     sel;
   logic        debug_take;
   logic [31:0] debug_instr;

   ib_ctl #(
      .ib_depth(ib_depth)
   ) u_ctl (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush        (flush),
      .fetch0_valid (fetch0.valid),
      .fetch1_valid (fetch1.valid),
      .debug_take   (debug_take),
      .decode0      (decode0),
      .decode1      (decode1),
      .ib_valid     (ib_valid),
      .sel          (sel)
   );

   ib_slots #(
      .ib_depth(ib_depth)
   ) u_slots (
      .clk          (clk),
      .rst_n        (rst_n),
      .sel          (sel),
      .fetch0_entry (fetch0.entry),
      .fetch1_entry (fetch1.entry),
      .debug_take   (debug_take),
      .debug_instr  (debug_instr),
      .slot0        (dec0),
      .slot1        (dec1)
   );

   dbg_inst_gen u_dbg (
      .clk             (clk),
      .rst_n           (rst_n),
      .dbg_cmd         (dbg_cmd),
      .debug_take      (debug_take),
      .debug_instr     (debug_instr),
      .debug_wdata_rs1 (debug_wdata_rs1),
      .debug_fence     (debug_fence)
   );

endmodule

`default_nettype wire

//--- design/dbg_inst_gen.sv
// turns an abstract debug command into a synthetic instruction for slot 0
// only gpr and csr commands are taken, mem and reserved types are ignored
// commands are assumed to arrive only while the core is halted and the buffer empty
// rs1 data and fence pulses follow one cycle after the command

`timescale 1ns/1ps
`default_nettype none

module dbg_inst_gen (
   input  logic                 clk,
   input  logic                 rst_n,
   input  dec_ib_pkg::dbg_cmd_t dbg_cmd,
   output logic                 debug_take,
   output logic [31:0]          debug_instr,
   output logic                 debug_wdata_rs1,
   output logic                 debug_fence
);
   import dec_ib_pkg::*;

   logic        is_gpr;
   logic        is_csr;
   logic        rd_gpr;
   logic        wr_gpr;
   logic        rd_csr;
   logic        wr_csr;
   logic [4:0]  dreg;
   logic [11:0] dcsr;

   assign is_gpr = dbg_cmd.valid & (dbg_cmd.cmd_type == dbg_gpr);
   assign is_csr = dbg_cmd.valid & (dbg_cmd.cmd_type == dbg_csr);

   assign rd_gpr = is_gpr & ~dbg_cmd.write;
   assign wr_gpr = is_gpr &  dbg_cmd.write;
   assign rd_csr = is_csr & ~dbg_cmd.write;
   assign wr_csr = is_csr &  dbg_cmd.write;

   assign dreg = dbg_cmd.addr.gpr.regno;
   assign dcsr = dbg_cmd.addr.csr.addr;

   assign debug_take = is_gpr | is_csr;

   always_comb begin
      debug_instr = '0;
      if (rd_gpr) begin
         // or x0, reg, x0 puts the register on rs1
         debug_instr = or_opcode_bits | {12'b0, dreg, 15'b0};
      end else if (wr_gpr) begin
         // or reg, x0, x0 with the write data forced on rs1
         debug_instr = or_opcode_bits | {20'b0, dreg, 7'b0};
      end else if (rd_csr) begin
         debug_instr = csrrs_low_bits | {dcsr, 20'b0};
      end else if (wr_csr) begin
         debug_instr = csrrw_low_bits | {dcsr, 20'b0};
      end
   end

   // pipe is empty when halted so the write reaches rs1 the next cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         debug_wdata_rs1 <= 1'b0;
         debug_fence     <= 1'b0;
      end else begin
         debug_wdata_rs1 <= wr_gpr | wr_csr;
         debug_fence     <= wr_csr & (dcsr == debug_fence_csr);  // debug-only fence csr
      end
   end

endmodule

`default_nettype wire

//--- design/ib_slots.sv
// entry storage for the instruction buffer
// each slot loads only when one of its selects is set, selects are one-hot
// a debug take replaces lane 0 for slot 0 with a clean 4-byte entry

`timescale 1ns/1ps
`default_nettype none

module ib_slots #(
   parameter int ib_depth = 4
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  dec_ib_pkg::ib_sel_t   sel,
   input  dec_ib_pkg::ib_entry_t fetch0_entry,
   input  dec_ib_pkg::ib_entry_t fetch1_entry,
   input  logic                  debug_take,
   input  logic [31:0]           debug_instr,
   output dec_ib_pkg::ib_entry_t slot0,
   output dec_ib_pkg::ib_entry_t slot1
);
   import dec_ib_pkg::*;

   ib_entry_t slot_q [ib_depth];
   ib_entry_t dbg_entry;

   // no pc and no faults for the synthetic instruction
   always_comb begin
      dbg_entry       = '0;
      dbg_entry.instr = debug_instr;
      dbg_entry.pc4   = 1'b1;
   end

   for (genvar i = 0; i < ib_depth; i++) begin : g_slot
      ib_entry_t lane0;
      ib_entry_t up1;
      ib_entry_t up2;
      ib_entry_t slot_d;

      if (i == 0) begin : g_dbg
         assign lane0 = debug_take ? dbg_entry : fetch0_entry;
      end else begin : g_lane
         assign lane0 = fetch0_entry;
      end

      if (i + 1 < ib_depth) begin : g_up1
         assign up1 = slot_q[i+1];
      end else begin : g_top1
         assign up1 = '0;             // nothing above the top slot
      end

      if (i + 2 < ib_depth) begin : g_up2
         assign up2 = slot_q[i+2];
      end else begin : g_top2
         assign up2 = '0;
      end

      always_comb begin
         if (sel.wr0[i]) begin
            slot_d = lane0;
         end else if (sel.wr1[i]) begin
            slot_d = fetch1_entry;
         end else if (sel.sh1[i]) begin
            slot_d = up1;
         end else if (sel.sh2[i]) begin
            slot_d = up2;
         end else begin
            slot_d = slot_q[i];     // hold
         end
      end

      always_ff @(posedge clk) begin
         if (!rst_n) begin
            slot_q[i] <= '0;
         end else begin
            slot_q[i] <= slot_d;
         end
      end
   end

   assign slot0 = slot_q[0];
   assign slot1 = slot_q[1];

endmodule

`default_nettype wire

//--- design/ib_ctl.sv
// valid bits and per-slot selects of the instruction buffer
// ib_valid is assumed contiguous from slot 0, decode1 only with decode0
// room is judged on the valid bits before the decode shift
// a registered flush refuses offers for one cycle and clears all valid bits

`timescale 1ns/1ps
`default_nettype none

module ib_ctl #(
   parameter int ib_depth = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                flush,
   input  logic                fetch0_valid,
   input  logic                fetch1_valid,
   input  logic                debug_take,
   input  logic                decode0,
   input  logic                decode1,
   output logic [ib_depth-1:0] ib_valid,
   output dec_ib_pkg::ib_sel_t sel
);
   import dec_ib_pkg::*;

   // slots that exist for this depth
   localparam logic [ib_max_depth-1:0] slot_mask = ib_max_depth'((1 << ib_depth) - 1);

   logic                    flush_q;
   logic                    take0;
   logic                    take1;
   logic                    shift1;
   logic                    shift2;
   logic [ib_max_depth-1:0] cur_val;     // valid bits widened to ib_max_depth
   logic [ib_max_depth-1:0] shift_val;   // valid bits after the decode shift
   logic [ib_max_depth-1:0] first_free;
   logic [ib_max_depth-1:0] fill;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flush_q <= 1'b0;
      end else begin
         flush_q <= flush;
      end
   end

   // room rule
   assign take0 = fetch0_valid & ~ib_valid[ib_depth-1] & ~flush_q;
   assign take1 = fetch1_valid & ~ib_valid[ib_depth-2] & ~flush_q;

   assign shift1 = decode0 & ~decode1;
   assign shift2 = decode0 & decode1;

   always_comb begin
      cur_val = '0;
      cur_val[ib_depth-1:0] = ib_valid;
   end

   always_comb begin
      if (shift2) begin
         shift_val = cur_val >> 2;
      end else if (shift1) begin
         shift_val = cur_val >> 1;
      end else begin
         shift_val = cur_val;
      end
   end

   // lowest slot still empty once the shift is done
   assign first_free = {shift_val[ib_max_depth-2:0], 1'b1} & ~shift_val & slot_mask;

   always_comb begin
      sel     = '0;
      sel.sh1 = {ib_max_depth{shift1}} & (cur_val >> 1);
      sel.sh2 = {ib_max_depth{shift2}} & (cur_val >> 2);
      sel.wr0 = {ib_max_depth{take0}} & first_free;
      // lane 1 lands right above lane 0
      sel.wr1 = {ib_max_depth{take1}} & (first_free << 1) & slot_mask;
      // debug instruction always goes to slot 0, the buffer is empty when halted
      sel.wr0[0] = sel.wr0[0] | debug_take;
   end

   assign fill = shift_val | sel.wr0 | sel.wr1;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ib_valid <= '0;
      end else if (flush_q) begin
         ib_valid <= '0;
      end else begin
         ib_valid <= fill[ib_depth-1:0];
      end
   end

endmodule

`default_nettype wire

//--- design/dec_ib_pkg.sv
// shared types and encodings for the dual-issue instruction buffer
// pc holds a halfword address, byte address bit 0 is not stored
// ib_max_depth is the upper bound for the ib_depth parameter

`default_nettype none

package dec_ib_pkg;

   localparam int ib_max_depth = 4;

   // one buffered instruction with its fetch status
   typedef struct packed {
      logic [31:0] instr;
      logic [31:1] pc;
      logic        pc4;          // 4-byte instruction, else 2-byte
      logic        icaf;         // access fault
      logic        icaf_second;  // access fault on second half of a 4-byte inst
      logic        perr;         // parity error
      logic        sbecc;        // single-bit ecc
      logic        dbecc;        // double-bit ecc
   } ib_entry_t;

   // one fetch lane
   typedef struct packed {
      logic      valid;
      ib_entry_t entry;
   } ib_fetch_t;

   typedef enum logic [1:0] {
      dbg_gpr      = 2'd0,
      dbg_csr      = 2'd1,
      dbg_mem      = 2'd2,     // handled outside the buffer
      dbg_reserved = 2'd3
   } dbg_type_e;

   // abstract command address, read as a gpr number or as a csr address
   typedef union packed {
      logic [31:0] word;
      struct packed {
         logic [26:0] unused;
         logic [4:0]  regno;
      } gpr;
      struct packed {
         logic [19:0] unused;
         logic [11:0] addr;
      } csr;
   } dbg_addr_u;

   typedef struct packed {
      logic      valid;
      logic      write;
      dbg_type_e cmd_type;
      dbg_addr_u addr;
   } dbg_cmd_t;

   // per-slot selects, bit i belongs to slot i
   typedef struct packed {
      logic [ib_max_depth-1:0] wr0;  // load from fetch lane 0
      logic [ib_max_depth-1:0] wr1;  // load from fetch lane 1
      logic [ib_max_depth-1:0] sh1;  // load from slot i+1
      logic [ib_max_depth-1:0] sh2;  // load from slot i+2
   } ib_sel_t;

   // fixed fields of the synthetic instructions, register or csr is or'ed in
   localparam logic [31:0] or_opcode_bits  = 32'h0000_6033;  // or, funct3 110
   localparam logic [31:0] csrrs_low_bits  = 32'h0000_2073;  // rd=x0 rs1=x0
   localparam logic [31:0] csrrw_low_bits  = 32'h0000_1073;
   localparam logic [11:0] debug_fence_csr = 12'h7c4;

endpackage

`default_nettype wire
